// ==== soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_resp_t resp_okay = 2'b00;

    // Address map
    localparam axi_addr_t uart_data_addr         = 32'ha00003f8;
    localparam axi_addr_t clint_mtimecmp_lo_addr = 32'h02004000;
    localparam axi_addr_t clint_mtimecmp_hi_addr = 32'h02004004;
    localparam axi_addr_t clint_mtime_lo_addr    = 32'h0200bff8;
    localparam axi_addr_t clint_mtime_hi_addr    = 32'h0200bffc;

    // SRAM depth in 32-bit words
    localparam int sram_words = 1024;

    typedef enum logic [1:0] {
        sel_sram,
        sel_uart,
        sel_clint
    } slave_sel_t;

endpackage

`default_nettype wire

// ==== axi_xbar.sv ====
`default_nettype none

module axi_xbar (
    input  logic                   clk,
    input  logic                   rst,
    // Master side
    input  soc_bus_pkg::axi_addr_t m_araddr,
    input  logic                   m_arvalid,
    output logic                   m_arready,
    output soc_bus_pkg::axi_data_t m_rdata,
    output soc_bus_pkg::axi_resp_t m_rresp,
    output logic                   m_rvalid,
    input  logic                   m_rready,
    input  soc_bus_pkg::axi_addr_t m_awaddr,
    input  logic                   m_awvalid,
    output logic                   m_awready,
    input  soc_bus_pkg::axi_data_t m_wdata,
    input  soc_bus_pkg::axi_strb_t m_wstrb,
    input  logic                   m_wvalid,
    output logic                   m_wready,
    output soc_bus_pkg::axi_resp_t m_bresp,
    output logic                   m_bvalid,
    input  logic                   m_bready,
    // s0 SRAM
    output soc_bus_pkg::axi_addr_t s0_araddr, s0_awaddr,
    output soc_bus_pkg::axi_data_t s0_wdata,
    output soc_bus_pkg::axi_strb_t s0_wstrb,
    output logic                   s0_arvalid, s0_rready, s0_awvalid, s0_wvalid, s0_bready,
    input  logic                   s0_arready, s0_rvalid, s0_awready, s0_wready, s0_bvalid,
    input  soc_bus_pkg::axi_data_t s0_rdata,
    input  soc_bus_pkg::axi_resp_t s0_rresp, s0_bresp,
    // s1 UART
    output soc_bus_pkg::axi_addr_t s1_araddr, s1_awaddr,
    output soc_bus_pkg::axi_data_t s1_wdata,
    output soc_bus_pkg::axi_strb_t s1_wstrb,
    output logic                   s1_arvalid, s1_rready, s1_awvalid, s1_wvalid, s1_bready,
    input  logic                   s1_arready, s1_rvalid, s1_awready, s1_wready, s1_bvalid,
    input  soc_bus_pkg::axi_data_t s1_rdata,
    input  soc_bus_pkg::axi_resp_t s1_rresp, s1_bresp,
    // s2 CLINT
    output soc_bus_pkg::axi_addr_t s2_araddr, s2_awaddr,
    output soc_bus_pkg::axi_data_t s2_wdata,
    output soc_bus_pkg::axi_strb_t s2_wstrb,
    output logic                   s2_arvalid, s2_rready, s2_awvalid, s2_wvalid, s2_bready,
    input  logic                   s2_arready, s2_rvalid, s2_awready, s2_wready, s2_bvalid,
    input  soc_bus_pkg::axi_data_t s2_rdata,
    input  soc_bus_pkg::axi_resp_t s2_rresp, s2_bresp
);

    soc_bus_pkg::slave_sel_t rd_route, wr_route, rd_sel, wr_sel;
    logic                    rd_busy, wr_busy;
    logic [2:0]              rd_hot, wr_hot;

    function automatic soc_bus_pkg::slave_sel_t decode(input soc_bus_pkg::axi_addr_t addr);
        soc_bus_pkg::slave_sel_t sel;
        sel = soc_bus_pkg::sel_sram;
        if (addr == soc_bus_pkg::uart_data_addr) begin
            sel = soc_bus_pkg::sel_uart;
        end else if (addr == soc_bus_pkg::clint_mtimecmp_lo_addr ||
                     addr == soc_bus_pkg::clint_mtimecmp_hi_addr ||
                     addr == soc_bus_pkg::clint_mtime_lo_addr ||
                     addr == soc_bus_pkg::clint_mtime_hi_addr) begin
            sel = soc_bus_pkg::sel_clint;
        end
        return sel;
    endfunction

    // Latched route while busy, fresh decode otherwise
    assign rd_sel = rd_busy ? rd_route : decode(m_araddr);
    assign wr_sel = wr_busy ? wr_route : decode(m_awaddr);
    assign rd_hot = 3'b001 << rd_sel;
    assign wr_hot = 3'b001 << wr_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            rd_route <= soc_bus_pkg::sel_sram;
            wr_route <= soc_bus_pkg::sel_sram;
        end else begin
            if (m_arvalid && m_arready) begin
                rd_busy  <= 1'b1;
                rd_route <= rd_sel;
            end else if (m_rvalid && m_rready) begin
                rd_busy <= 1'b0;
            end
            if (m_awvalid && m_awready) begin
                wr_busy  <= 1'b1;
                wr_route <= wr_sel;
            end else if (m_bvalid && m_bready) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // Payloads go to every slave, handshakes only to the routed one
    assign s0_araddr = m_araddr;
    assign s1_araddr = m_araddr;
    assign s2_araddr = m_araddr;
    assign s0_awaddr = m_awaddr;
    assign s1_awaddr = m_awaddr;
    assign s2_awaddr = m_awaddr;
    assign s0_wdata  = m_wdata;
    assign s1_wdata  = m_wdata;
    assign s2_wdata  = m_wdata;
    assign s0_wstrb  = m_wstrb;
    assign s1_wstrb  = m_wstrb;
    assign s2_wstrb  = m_wstrb;

    assign {s2_arvalid, s1_arvalid, s0_arvalid} = rd_hot & {3{m_arvalid && !rd_busy}};
    assign {s2_rready, s1_rready, s0_rready}    = rd_hot & {3{m_rready && rd_busy}};
    assign {s2_awvalid, s1_awvalid, s0_awvalid} = wr_hot & {3{m_awvalid && !wr_busy}};
    assign {s2_wvalid, s1_wvalid, s0_wvalid}    = wr_hot & {3{m_wvalid && !wr_busy}};
    assign {s2_bready, s1_bready, s0_bready}    = wr_hot & {3{m_bready && wr_busy}};

    assign m_arready = !rd_busy && |(rd_hot & {s2_arready, s1_arready, s0_arready});
    assign m_rvalid  = rd_busy && |(rd_hot & {s2_rvalid, s1_rvalid, s0_rvalid});
    assign m_awready = !wr_busy && |(wr_hot & {s2_awready, s1_awready, s0_awready});
    assign m_wready  = !wr_busy && |(wr_hot & {s2_wready, s1_wready, s0_wready});
    assign m_bvalid  = wr_busy && |(wr_hot & {s2_bvalid, s1_bvalid, s0_bvalid});

    always_comb begin
        case (rd_route)
            soc_bus_pkg::sel_uart: begin
                m_rdata = s1_rdata;
                m_rresp = s1_rresp;
            end
            soc_bus_pkg::sel_clint: begin
                m_rdata = s2_rdata;
                m_rresp = s2_rresp;
            end
            default: begin
                m_rdata = s0_rdata;
                m_rresp = s0_rresp;
            end
        endcase
        case (wr_route)
            soc_bus_pkg::sel_uart:  m_bresp = s1_bresp;
            soc_bus_pkg::sel_clint: m_bresp = s2_bresp;
            default:                m_bresp = s0_bresp;
        endcase
    end

endmodule

`default_nettype wire

// ==== axi_sram.sv ====
`default_nettype none

module axi_sram (
    input  logic                   clk,
    input  logic                   rst,
    input  soc_bus_pkg::axi_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output soc_bus_pkg::axi_data_t rdata,
    output soc_bus_pkg::axi_resp_t rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  soc_bus_pkg::axi_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  soc_bus_pkg::axi_data_t wdata,
    input  soc_bus_pkg::axi_strb_t wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output soc_bus_pkg::axi_resp_t bresp,
    output logic                   bvalid,
    input  logic                   bready
);

    soc_bus_pkg::axi_data_t mem [soc_bus_pkg::sram_words];
    logic                   rd_fire, wr_fire;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;
    // AW and W taken together
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign rresp   = soc_bus_pkg::resp_okay;
    assign bresp   = soc_bus_pkg::resp_okay;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= mem[araddr[11:2]];
        end
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[awaddr[11:2]][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== axi_uart_tx.sv ====
`default_nettype none

module axi_uart_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  soc_bus_pkg::axi_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output soc_bus_pkg::axi_data_t rdata,
    output soc_bus_pkg::axi_resp_t rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  soc_bus_pkg::axi_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  soc_bus_pkg::axi_data_t wdata,
    input  soc_bus_pkg::axi_strb_t wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output soc_bus_pkg::axi_resp_t bresp,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [7:0]             tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready
);

    logic wr_fire, wr_hit;

    assign arready = !rvalid;
    // B stays pending from the write until the byte is taken and acknowledged
    assign wr_fire = awvalid && wvalid && !tx_valid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign wr_hit  = (awaddr == soc_bus_pkg::uart_data_addr) && wstrb[0];
    assign rresp   = soc_bus_pkg::resp_okay;
    assign bresp   = soc_bus_pkg::resp_okay;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            tx_valid <= 1'b0;
            tx_data  <= 8'h00;
        end else begin
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire && wr_hit) begin
                tx_valid <= 1'b1;
                tx_data  <= wdata[7:0];
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
            // Writes that miss the data register complete at once
            if ((wr_fire && !wr_hit) || (tx_valid && tx_ready)) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= (araddr == soc_bus_pkg::uart_data_addr) ? {24'h0, tx_data} : '0;
        end
    end

endmodule

`default_nettype wire

// ==== axi_clint.sv ====
`default_nettype none

module axi_clint (
    input  logic                   clk,
    input  logic                   rst,
    input  soc_bus_pkg::axi_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output soc_bus_pkg::axi_data_t rdata,
    output soc_bus_pkg::axi_resp_t rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  soc_bus_pkg::axi_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  soc_bus_pkg::axi_data_t wdata,
    input  soc_bus_pkg::axi_strb_t wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output soc_bus_pkg::axi_resp_t bresp,
    output logic                   bvalid,
    input  logic                   bready,
    output logic                   timer_irq
);

    logic [63:0] mtime, mtimecmp, rd_word;
    logic        wr_fire;

    // Byte-strobed update of one 32-bit half
    function automatic logic [63:0] merge(input logic [63:0] cur, input logic hi,
                                          input soc_bus_pkg::axi_data_t data,
                                          input soc_bus_pkg::axi_strb_t strb);
        logic [63:0] res;
        res = cur;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[32*hi + 8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign arready = !rvalid;
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign rresp   = soc_bus_pkg::resp_okay;
    assign bresp   = soc_bus_pkg::resp_okay;
    // Bit 15 picks mtime over mtimecmp
    assign rd_word = araddr[15] ? mtime : mtimecmp;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid    <= 1'b0;
            bvalid    <= 1'b0;
            mtime     <= '0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire && awaddr[15]) begin
                mtime <= merge(mtime + 64'd1, awaddr[2], wdata, wstrb);
            end else begin
                mtime <= mtime + 64'd1;
            end
            if (wr_fire && !awaddr[15]) begin
                mtimecmp <= merge(mtimecmp, awaddr[2], wdata, wstrb);
            end
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= araddr[2] ? rd_word[63:32] : rd_word[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== soc_bus_top.sv ====
`default_nettype none

module soc_bus_top (
    input  logic                   clk,
    input  logic                   rst,
    input  soc_bus_pkg::axi_addr_t araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output soc_bus_pkg::axi_data_t rdata,
    output soc_bus_pkg::axi_resp_t rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  soc_bus_pkg::axi_addr_t awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  soc_bus_pkg::axi_data_t wdata,
    input  soc_bus_pkg::axi_strb_t wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output soc_bus_pkg::axi_resp_t bresp,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [7:0]             tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic                   timer_irq
);

    soc_bus_pkg::axi_addr_t s0_araddr, s0_awaddr, s1_araddr, s1_awaddr, s2_araddr, s2_awaddr;
    soc_bus_pkg::axi_data_t s0_rdata, s0_wdata, s1_rdata, s1_wdata, s2_rdata, s2_wdata;
    soc_bus_pkg::axi_strb_t s0_wstrb, s1_wstrb, s2_wstrb;
    soc_bus_pkg::axi_resp_t s0_rresp, s0_bresp, s1_rresp, s1_bresp, s2_rresp, s2_bresp;
    logic s0_arvalid, s0_arready, s0_rvalid, s0_rready, s0_awvalid, s0_awready;
    logic s0_wvalid, s0_wready, s0_bvalid, s0_bready;
    logic s1_arvalid, s1_arready, s1_rvalid, s1_rready, s1_awvalid, s1_awready;
    logic s1_wvalid, s1_wready, s1_bvalid, s1_bready;
    logic s2_arvalid, s2_arready, s2_rvalid, s2_rready, s2_awvalid, s2_awready;
    logic s2_wvalid, s2_wready, s2_bvalid, s2_bready;

    // Slave-side names match the wires above
    axi_xbar u_xbar (
        .m_araddr  (araddr),
        .m_arvalid (arvalid),
        .m_arready (arready),
        .m_rdata   (rdata),
        .m_rresp   (rresp),
        .m_rvalid  (rvalid),
        .m_rready  (rready),
        .m_awaddr  (awaddr),
        .m_awvalid (awvalid),
        .m_awready (awready),
        .m_wdata   (wdata),
        .m_wstrb   (wstrb),
        .m_wvalid  (wvalid),
        .m_wready  (wready),
        .m_bresp   (bresp),
        .m_bvalid  (bvalid),
        .m_bready  (bready),
        .*
    );

    axi_sram u_sram (
        .clk(clk), .rst(rst),
        .araddr(s0_araddr), .arvalid(s0_arvalid), .arready(s0_arready),
        .rdata(s0_rdata), .rresp(s0_rresp), .rvalid(s0_rvalid), .rready(s0_rready),
        .awaddr(s0_awaddr), .awvalid(s0_awvalid), .awready(s0_awready),
        .wdata(s0_wdata), .wstrb(s0_wstrb), .wvalid(s0_wvalid), .wready(s0_wready),
        .bresp(s0_bresp), .bvalid(s0_bvalid), .bready(s0_bready)
    );

    axi_uart_tx u_uart (
        .clk(clk), .rst(rst),
        .araddr(s1_araddr), .arvalid(s1_arvalid), .arready(s1_arready),
        .rdata(s1_rdata), .rresp(s1_rresp), .rvalid(s1_rvalid), .rready(s1_rready),
        .awaddr(s1_awaddr), .awvalid(s1_awvalid), .awready(s1_awready),
        .wdata(s1_wdata), .wstrb(s1_wstrb), .wvalid(s1_wvalid), .wready(s1_wready),
        .bresp(s1_bresp), .bvalid(s1_bvalid), .bready(s1_bready),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
    );

    axi_clint u_clint (
        .clk(clk), .rst(rst),
        .araddr(s2_araddr), .arvalid(s2_arvalid), .arready(s2_arready),
        .rdata(s2_rdata), .rresp(s2_rresp), .rvalid(s2_rvalid), .rready(s2_rready),
        .awaddr(s2_awaddr), .awvalid(s2_awvalid), .awready(s2_awready),
        .wdata(s2_wdata), .wstrb(s2_wstrb), .wvalid(s2_wvalid), .wready(s2_wready),
        .bresp(s2_bresp), .bvalid(s2_bvalid), .bready(s2_bready),
        .timer_irq(timer_irq)
    );

endmodule

`default_nettype wire

// ==== soc_bus_chk.sv ====
`default_nettype none

module soc_bus_chk (
    input logic                   clk,
    input logic                   rst,
    input soc_bus_pkg::axi_addr_t m_araddr,
    input soc_bus_pkg::axi_addr_t m_awaddr,
    input logic                   m_arvalid,
    input logic                   m_arready,
    input logic                   m_awvalid,
    input logic                   m_awready,
    input logic                   m_bvalid,
    input logic                   m_bready,
    input logic [2:0]             arvalid_sel,
    input logic [2:0]             awvalid_sel,
    input logic [2:0]             rvalid_sel,
    input logic [2:0]             bvalid_sel
);

    ar_held: assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
        else $error("AR valid or address changed before arready");

    aw_held: assert property (@(posedge clk) disable iff (rst)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
        else $error("AW valid or address changed before awready");

    b_held: assert property (@(posedge clk) disable iff (rst)
        m_bvalid && !m_bready |=> m_bvalid)
        else $error("B valid dropped before bready");

    // Never two slaves addressed or responding at once
    ar_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(arvalid_sel | rvalid_sel))
        else $error("More than one slave active on the read side");

    aw_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(awvalid_sel | bvalid_sel))
        else $error("More than one slave active on the write side");

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 16 rising edges
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== soc_bus_tb.sv ====
`default_nettype none

module soc_bus_tb;

    localparam int wait_limit = 64;

    logic                   clk, rst;
    soc_bus_pkg::axi_addr_t araddr, awaddr;
    soc_bus_pkg::axi_data_t rdata, wdata;
    soc_bus_pkg::axi_strb_t wstrb;
    soc_bus_pkg::axi_resp_t rresp, bresp;
    logic                   arvalid, arready, rvalid, rready, awvalid, awready;
    logic                   wvalid, wready, bvalid, bready;
    logic [7:0]             tx_data;
    logic                   tx_valid, tx_ready, timer_irq;

    logic [31:0]            seed = 32'h264481e4;
    int                     checks = 0;
    int                     errors = 0;
    int                     timeouts = 0;
    int unsigned            cycle = 0;
    // Expected SRAM contents, one entry per word
    soc_bus_pkg::axi_data_t model [soc_bus_pkg::sram_words];
    soc_bus_pkg::axi_addr_t addrs [$];

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    soc_bus_top u_dut (.*);

    bind axi_xbar soc_bus_chk u_chk (
        .clk(clk), .rst(rst), .m_araddr(m_araddr), .m_awaddr(m_awaddr),
        .m_arvalid(m_arvalid), .m_arready(m_arready), .m_awvalid(m_awvalid),
        .m_awready(m_awready), .m_bvalid(m_bvalid), .m_bready(m_bready),
        .arvalid_sel({s2_arvalid, s1_arvalid, s0_arvalid}),
        .awvalid_sel({s2_awvalid, s1_awvalid, s0_awvalid}),
        .rvalid_sel({s2_rvalid, s1_rvalid, s0_rvalid}),
        .bvalid_sel({s2_bvalid, s1_bvalid, s0_bvalid})
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic soc_bus_pkg::axi_data_t merge_bytes(input soc_bus_pkg::axi_data_t old_word,
            input soc_bus_pkg::axi_data_t new_word, input soc_bus_pkg::axi_strb_t strb);
        soc_bus_pkg::axi_data_t res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic expect_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAILED %s expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic expect_okay(input string test, input soc_bus_pkg::axi_resp_t resp);
        checks++;
        assert (resp === soc_bus_pkg::resp_okay) else begin
            errors++;
            $display("FAILED %s expected %h actual %h", test, soc_bus_pkg::resp_okay, resp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Check failed: %s", what);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s", what);
    endtask

    task automatic axi_write(input soc_bus_pkg::axi_addr_t addr, input soc_bus_pkg::axi_data_t data,
                             input soc_bus_pkg::axi_strb_t strb,
                             output soc_bus_pkg::axi_resp_t resp);
        int n;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!(awready && wready) && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (!(awready && wready)) begin
            note_timeout("awready and wready");
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(posedge clk);
        while (!bvalid && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (!bvalid) begin
            note_timeout("bvalid");
        end
        // B is seen with bready low, so it must hold one more cycle
        bready <= 1'b1;
        @(posedge clk);
        expect_true(bvalid, "bvalid dropped before bready");
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic read_addr(input soc_bus_pkg::axi_addr_t addr);
        int n;
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(posedge clk);
        while (!arready && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (!arready) begin
            note_timeout("arready");
        end
        arvalid <= 1'b0;
    endtask

    // Entered at the AR transfer edge; rready stays low for hold cycles
    task automatic read_data(input int hold, output soc_bus_pkg::axi_data_t data,
                             output soc_bus_pkg::axi_resp_t resp);
        int n;
        int i;
        n = 1;
        @(posedge clk);
        while (!rvalid && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (!rvalid) begin
            note_timeout("rvalid");
        end
        expect_eq("read latency", 1, n);
        data = rdata;
        for (i = 0; i < hold; i++) begin
            @(posedge clk);
            expect_true(rvalid && !arready && rdata == data,
                        "read response or arready changed while rready was low");
        end
        rready <= 1'b1;
        @(posedge clk);
        expect_true(rvalid, "rvalid dropped before rready");
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic axi_read(input soc_bus_pkg::axi_addr_t addr, output soc_bus_pkg::axi_data_t data,
                            output soc_bus_pkg::axi_resp_t resp);
        read_addr(addr);
        read_data(0, data, resp);
    endtask

    task automatic sram_write(input string test, input soc_bus_pkg::axi_addr_t addr,
                              input soc_bus_pkg::axi_data_t data,
                              input soc_bus_pkg::axi_strb_t strb);
        soc_bus_pkg::axi_resp_t resp;
        axi_write(addr, data, strb, resp);
        expect_okay(test, resp);
        model[addr[11:2]] = merge_bytes(model[addr[11:2]], data, strb);
    endtask

    task automatic sram_check(input string test, input soc_bus_pkg::axi_addr_t addr);
        soc_bus_pkg::axi_data_t data;
        soc_bus_pkg::axi_resp_t resp;
        axi_read(addr, data, resp);
        expect_eq(test, model[addr[11:2]], data);
        expect_okay(test, resp);
    endtask

    // Takes one byte from the tx stream after stalling it
    task automatic uart_sink(input int stall, output logic [7:0] got);
        int n;
        int i;
        n = 0;
        @(posedge clk);
        while (!tx_valid && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (!tx_valid) begin
            note_timeout("tx_valid");
        end
        got = tx_data;
        for (i = 0; i < stall; i++) begin
            @(posedge clk);
            expect_true(tx_valid && tx_data == got && !bvalid,
                        "UART byte changed or B response came while tx_ready was low");
        end
        tx_ready <= 1'b1;
        @(posedge clk);
        tx_ready <= 1'b0;
    endtask

    task automatic test_reset();
        expect_true(!rvalid && !bvalid && !tx_valid && !timer_irq, "outputs not idle after reset");
    endtask

    task automatic test_sram();
        logic [31:0]            word;
        soc_bus_pkg::axi_addr_t addr;
        soc_bus_pkg::axi_strb_t strb;
        for (int i = 0; i < 6; i++) begin
            word = lcg_next();
            addr = {20'h0, word[11:2], 2'b00};
            addrs.push_back(addr);
            sram_write("sram full write", addr, lcg_next(), 4'hf);
        end
        foreach (addrs[i]) begin
            word = lcg_next();
            strb = word[3:0];
            if (strb == 4'hf || strb == 4'h0) begin
                strb = 4'b0101;
            end
            sram_write("sram strobed write", addrs[i], lcg_next(), strb);
        end
        foreach (addrs[i]) begin
            sram_check("sram readback", addrs[i]);
        end
    endtask

    task automatic test_uart();
        soc_bus_pkg::axi_resp_t resp;
        soc_bus_pkg::axi_data_t data;
        logic [7:0]             got;
        fork
            axi_write(soc_bus_pkg::uart_data_addr, 32'h123456a5, 4'hf, resp);
            uart_sink(6, got);
        join
        expect_eq("uart tx_data", 32'h000000a5, {24'h0, got});
        expect_okay("uart bresp", resp);
        axi_read(soc_bus_pkg::uart_data_addr, data, resp);
        expect_eq("uart readback", 32'h000000a5, data);
        expect_okay("uart rresp", resp);
    endtask

    task automatic test_clint();
        soc_bus_pkg::axi_data_t t1, t2;
        soc_bus_pkg::axi_resp_t resp;
        int unsigned            c1, c2;
        int                     n;
        c1 = cycle;
        axi_read(soc_bus_pkg::clint_mtime_lo_addr, t1, resp);
        repeat (12) @(posedge clk);
        c2 = cycle;
        axi_read(soc_bus_pkg::clint_mtime_lo_addr, t2, resp);
        expect_true(t2 - t1 >= c2 - c1, "mtime advanced by fewer ticks than elapsed cycles");
        // Low half first so the compare never passes early
        axi_read(soc_bus_pkg::clint_mtime_lo_addr, t1, resp);
        axi_write(soc_bus_pkg::clint_mtimecmp_lo_addr, t1 + 32'd50, 4'hf, resp);
        axi_write(soc_bus_pkg::clint_mtimecmp_hi_addr, 32'h0, 4'hf, resp);
        expect_okay("clint bresp", resp);
        n = 0;
        while (!timer_irq && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (!timer_irq) begin
            note_timeout("timer_irq");
        end
        expect_true(n >= 40, "timer_irq rose before mtime reached mtimecmp");
    endtask

    task automatic test_isolation();
        soc_bus_pkg::axi_addr_t aliases [5];
        soc_bus_pkg::axi_data_t data;
        soc_bus_pkg::axi_data_t uart_word;
        soc_bus_pkg::axi_resp_t resp;
        logic [7:0]             got;
        aliases = '{32'h000003f8, 32'h00000000, 32'h00000004, 32'h00000ff8, 32'h00000ffc};
        foreach (aliases[i]) begin
            sram_write("alias write", aliases[i], lcg_next(), 4'hf);
        end
        @(posedge clk);
        expect_true(!tx_valid, "UART emitted a byte for an SRAM write");
        axi_read(soc_bus_pkg::uart_data_addr, data, resp);
        expect_eq("uart register after alias writes", 32'h000000a5, data);
        // A UART write must leave the SRAM word at 0x3f8 alone
        uart_word = lcg_next();
        fork
            axi_write(soc_bus_pkg::uart_data_addr, uart_word, 4'hf, resp);
            uart_sink(0, got);
        join
        expect_eq("uart byte after alias writes", {24'h0, uart_word[7:0]}, {24'h0, got});
        axi_write(soc_bus_pkg::clint_mtimecmp_hi_addr, 32'hffffffff, 4'hf, resp);
        axi_read(soc_bus_pkg::clint_mtime_lo_addr, data, resp);
        foreach (aliases[i]) begin
            sram_check("alias readback", aliases[i]);
        end
    endtask

    task automatic test_backpressure();
        soc_bus_pkg::axi_data_t d1, d2;
        soc_bus_pkg::axi_resp_t r1, r2;
        read_addr(addrs[0]);
        // Second request waits behind the stalled response
        araddr  <= addrs[1];
        arvalid <= 1'b1;
        read_data(6, d1, r1);
        read_addr(addrs[1]);
        read_data(0, d2, r2);
        expect_eq("backpressure first read", model[addrs[0][11:2]], d1);
        expect_eq("backpressure second read", model[addrs[1][11:2]], d2);
        expect_okay("backpressure first rresp", r1);
        expect_okay("backpressure second rresp", r2);
    endtask

    initial begin
        int n;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        tx_ready = 1'b0;
        n = 0;
        @(posedge clk);
        while (rst && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (rst) begin
            note_timeout("reset release");
        end
        test_reset();
        test_sram();
        test_uart();
        test_clint();
        test_isolation();
        test_backpressure();
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
soc_bus_pkg.sv
axi_xbar.sv
axi_sram.sv
axi_uart_tx.sv
axi_clint.sv
soc_bus_top.sv
soc_bus_chk.sv
tb_clk_gen.sv
soc_bus_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert --top-module soc_bus_tb -f verilog.f -o soc_bus_sim
./obj_dir/soc_bus_sim | tee sim.log
if grep -q "test passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi
